/* hw/cpuPipeCfg.svh */
`ifndef CPU_PIPE_CFG_SVH
`define CPU_PIPE_CFG_SVH

// datapath and storage sizes
`define CPU_XLEN        32
`define CPU_REG_COUNT   32
`define CPU_IMEM_WORDS  32
`define CPU_DMEM_WORDS  32

// first fetch comes from word 25
`define CPU_RESET_PC    32'd100

// register i resets to i * step, so r0 comes out as zero
`define CPU_REG_INIT_STEP   32'h01000001

// data word i resets to base + i * step
`define CPU_DMEM_INIT_BASE  32'hA0000000
`define CPU_DMEM_INIT_STEP  32'h00110011

`endif

/* hw/isaPkg.sv */
`include "cpuPipeCfg.svh"

package isaPkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;
    typedef logic [$clog2(`CPU_IMEM_WORDS)-1:0] imemAddr_t;

    // primary opcode, bits 31:26
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'b000000,
        OP_LW    = 6'b100011
    } opcode_e;

    // function code of the register form, bits 5:0
    typedef enum logic [5:0]
    {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_XOR = 6'b100110
    } funct_e;

    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } aluOp_e;

endpackage

/* hw/pipePkg.sv */
package pipePkg;

    // operand source picked in decode
    //   FWD_REG  register file, including the writeback bypass
    //   FWD_EXE  ALU result of the instruction now in execute
    //   FWD_MEM  result of the instruction now in memory
    typedef enum logic [1:0]
    {
        FWD_REG = 2'd0,
        FWD_EXE = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_e;

endpackage

/* hw/fetchStage.sv */
`timescale 1ns/1ps
`include "cpuPipeCfg.svh"

module fetchStage
(
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              imemWe,
    input  isaPkg::imemAddr_t imemAddr,
    input  isaPkg::word_t     imemData,
    output isaPkg::word_t     dInstr,
    output logic              dValid
);
    import isaPkg::*;

    word_t     pc;
    imemAddr_t pcWord;
    word_t     imem [`CPU_IMEM_WORDS];

    // word index of the pc, byte offset dropped
    assign pcWord = pc[2 +: $bits(imemAddr_t)];

    //////////////////////////////
    // program counter
    //////////////////////////////

    // holds while run is low, wraps at the end of imem
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `CPU_RESET_PC;
        else if (run)
            pc <= word_t'({imemAddr_t'(pcWord + 1'b1), 2'b00});
    end

    //////////////////////////////
    // instruction memory
    //////////////////////////////

    // loader port
    always_ff @(posedge clk)
    begin
        if (imemWe)
            imem[imemAddr] <= imemData;
    end

    //////////////////////////////
    // fetch/decode register
    //////////////////////////////

    // bubble when not running
    always_ff @(posedge clk)
    begin
        if (rst)
            dValid <= 1'b0;
        else
            dValid <= run;
    end

    always_ff @(posedge clk)
    begin
        dInstr <= imem[pcWord];
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "cpuPipeCfg.svh"

module regFile
(
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::regIdx_t rs,
    input  isaPkg::regIdx_t rt,
    input  logic            wbValid,
    input  isaPkg::regIdx_t wbReg,
    input  isaPkg::word_t   wbData,
    output isaPkg::word_t   qa,
    output isaPkg::word_t   qb
);
    import isaPkg::*;

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                regs[i] <= word_t'(i) * `CPU_REG_INIT_STEP;
        end
        else if (wbValid)
            regs[wbReg] <= wbData;
    end

    // same-cycle writeback shows through
    function automatic word_t readPort(input regIdx_t idx);
        if (wbValid && (wbReg == idx))
            return wbData;
        else
            return regs[idx];
    endfunction

    always_comb
    begin
        qa = readPort(rs);
        qb = readPort(rt);
    end

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps
`include "cpuPipeCfg.svh"

module decodeStage
(
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::word_t   dInstr,
    input  logic            dValid,
    input  isaPkg::word_t   exeResult,
    input  logic            mWreg,
    input  isaPkg::regIdx_t mDest,
    input  isaPkg::word_t   memFwdData,
    input  logic            wbValid,
    input  isaPkg::regIdx_t wbReg,
    input  isaPkg::word_t   wbData,
    output logic            eValid,
    output logic            eWreg,
    output logic            eIsLoad,
    output isaPkg::aluOp_e  eAluOp,
    output logic            eAluImm,
    output isaPkg::regIdx_t eDest,
    output isaPkg::word_t   eOpA,
    output isaPkg::word_t   eOpB,
    output isaPkg::word_t   eImm
);
    import isaPkg::*;
    import pipePkg::*;

    opcode_e opcode;
    funct_e  funct;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    regIdx_t dest;
    logic    wreg;
    logic    writeEn;
    logic    isLoad;
    logic    aluImm;
    aluOp_e  aluOp;
    word_t   qa;
    word_t   qb;
    word_t   opA;
    word_t   opB;
    word_t   imm;
    fwdSel_e fwdA;
    fwdSel_e fwdB;

    assign opcode = opcode_e'(dInstr[31:26]);
    assign funct  = funct_e'(dInstr[5:0]);
    assign rs     = dInstr[25:21];
    assign rt     = dInstr[20:16];
    assign rd     = dInstr[15:11];

    regFile uRegFile
    (
        .clk     (clk),
        .rst     (rst),
        .rs      (rs),
        .rt      (rt),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .qa      (qa),
        .qb      (qb)
    );

    //////////////////////////////
    // control decode
    //////////////////////////////

    // anything not recognised falls through as a nop
    always_comb
    begin
        wreg   = 1'b0;
        isLoad = 1'b0;
        aluImm = 1'b0;
        aluOp  = ALU_ADD;
        case (opcode)
            OP_RTYPE:
            begin
                wreg = 1'b1;
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    default: wreg = 1'b0;
                endcase
            end
            OP_LW:
            begin
                // address = rs + imm, result lands in rt
                wreg   = 1'b1;
                isLoad = 1'b1;
                aluImm = 1'b1;
            end
            default:
            begin
                wreg = 1'b0;
            end
        endcase
    end

    // immediate form writes rt, register form writes rd
    assign dest = aluImm ? rt : rd;

    // r0 writes die here
    assign writeEn = dValid && wreg && (dest != '0);

    assign imm = {{(`CPU_XLEN-16){dInstr[15]}}, dInstr[15:0]};

    //////////////////////////////
    // operand forwarding
    //////////////////////////////

    // the younger producer wins
    function automatic fwdSel_e fwdSelect(input regIdx_t src);
        if (eWreg && (eDest == src))
            return FWD_EXE;
        else if (mWreg && (mDest == src))
            return FWD_MEM;
        else
            return FWD_REG;
    endfunction

    function automatic word_t fwdMux(input fwdSel_e sel, input word_t regVal);
        case (sel)
            FWD_EXE: return exeResult;
            FWD_MEM: return memFwdData;
            default: return regVal;
        endcase
    endfunction

    always_comb
    begin
        fwdA = fwdSelect(rs);
        fwdB = fwdSelect(rt);
        opA  = fwdMux(fwdA, qa);
        opB  = fwdMux(fwdB, qb);
    end

    // a load still in execute only has its address, not its data
    noExeLoadFwd: assert property (@(posedge clk) disable iff (rst)
        !(dValid && wreg && eWreg && eIsLoad &&
          ((fwdA == FWD_EXE) || (!aluImm && (fwdB == FWD_EXE)))));

    //////////////////////////////
    // decode/execute register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eValid  <= 1'b0;
            eWreg   <= 1'b0;
            eIsLoad <= 1'b0;
        end
        else
        begin
            eValid  <= dValid;
            eWreg   <= writeEn;
            eIsLoad <= dValid && isLoad;
        end
    end

    always_ff @(posedge clk)
    begin
        eAluOp  <= aluOp;
        eAluImm <= aluImm;
        eDest   <= dest;
        eOpA    <= opA;
        eOpB    <= opB;
        eImm    <= imm;
    end

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ps

module executeStage
(
    input  logic            clk,
    input  logic            rst,
    input  logic            eValid,
    input  logic            eWreg,
    input  logic            eIsLoad,
    input  isaPkg::aluOp_e  eAluOp,
    input  logic            eAluImm,
    input  isaPkg::regIdx_t eDest,
    input  isaPkg::word_t   eOpA,
    input  isaPkg::word_t   eOpB,
    input  isaPkg::word_t   eImm,
    output isaPkg::word_t   exeResult,
    output logic            mWreg,
    output logic            mIsLoad,
    output isaPkg::regIdx_t mDest,
    output isaPkg::word_t   mResult
);
    import isaPkg::*;

    word_t aluB;

    assign aluB = eAluImm ? eImm : eOpB;

    // loads come through here as ALU_ADD to form the address
    always_comb
    begin
        case (eAluOp)
            ALU_ADD: exeResult = eOpA + aluB;
            ALU_SUB: exeResult = eOpA - aluB;
            ALU_AND: exeResult = eOpA & aluB;
            ALU_OR:  exeResult = eOpA | aluB;
            ALU_XOR: exeResult = eOpA ^ aluB;
            default: exeResult = '0;
        endcase
    end

    // decode only ever hands over one of the five ops
    legalAluOp: assert property (@(posedge clk) disable iff (rst)
        eValid |-> (eAluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR}));

    //////////////////////////////
    // execute/memory register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mWreg   <= 1'b0;
            mIsLoad <= 1'b0;
        end
        else
        begin
            mWreg   <= eWreg;
            mIsLoad <= eIsLoad;
        end
    end

    always_ff @(posedge clk)
    begin
        mDest   <= eDest;
        mResult <= exeResult;
    end

endmodule

/* hw/memWbStage.sv */
`timescale 1ns/1ps
`include "cpuPipeCfg.svh"

module memWbStage
(
    input  logic            clk,
    input  logic            rst,
    input  logic            mWreg,
    input  logic            mIsLoad,
    input  isaPkg::regIdx_t mDest,
    input  isaPkg::word_t   mResult,
    output isaPkg::word_t   memFwdData,
    output logic            wbValid,
    output isaPkg::regIdx_t wbReg,
    output isaPkg::word_t   wbData
);
    import isaPkg::*;

    localparam int dmemAw = $clog2(`CPU_DMEM_WORDS);

    word_t             dmem [`CPU_DMEM_WORDS];
    logic [dmemAw-1:0] dmemIdx;

    // byte address to word, upper bits wrap
    assign dmemIdx = mResult[2 +: dmemAw];

    // read-only after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++)
                dmem[i] <= `CPU_DMEM_INIT_BASE + word_t'(i) * `CPU_DMEM_INIT_STEP;
        end
    end

    // also what decode forwards from this stage
    assign memFwdData = mIsLoad ? dmem[dmemIdx] : mResult;

    //////////////////////////////
    // memory/writeback register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            wbValid <= 1'b0;
        else
            wbValid <= mWreg;
    end

    always_ff @(posedge clk)
    begin
        wbReg  <= mDest;
        wbData <= memFwdData;
    end

endmodule

/* hw/cpuPipeTop.sv */
`timescale 1ns/1ps

module cpuPipeTop
(
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              imemWe,
    input  isaPkg::imemAddr_t imemAddr,
    input  isaPkg::word_t     imemData,
    output logic              wbValid,
    output isaPkg::regIdx_t   wbReg,
    output isaPkg::word_t     wbData
);
    import isaPkg::*;

    // fetch -> decode
    word_t   dInstr;
    logic    dValid;

    // decode -> execute
    logic    eValid;
    logic    eWreg;
    logic    eIsLoad;
    aluOp_e  eAluOp;
    logic    eAluImm;
    regIdx_t eDest;
    word_t   eOpA;
    word_t   eOpB;
    word_t   eImm;

    // execute -> memory, plus forwarding paths
    word_t   exeResult;
    logic    mWreg;
    logic    mIsLoad;
    regIdx_t mDest;
    word_t   mResult;
    word_t   memFwdData;

    fetchStage uFetch
    (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .dInstr   (dInstr),
        .dValid   (dValid)
    );

    decodeStage uDecode
    (
        .clk        (clk),
        .rst        (rst),
        .dInstr     (dInstr),
        .dValid     (dValid),
        .exeResult  (exeResult),
        .mWreg      (mWreg),
        .mDest      (mDest),
        .memFwdData (memFwdData),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .eValid     (eValid),
        .eWreg      (eWreg),
        .eIsLoad    (eIsLoad),
        .eAluOp     (eAluOp),
        .eAluImm    (eAluImm),
        .eDest      (eDest),
        .eOpA       (eOpA),
        .eOpB       (eOpB),
        .eImm       (eImm)
    );

    executeStage uExecute
    (
        .clk       (clk),
        .rst       (rst),
        .eValid    (eValid),
        .eWreg     (eWreg),
        .eIsLoad   (eIsLoad),
        .eAluOp    (eAluOp),
        .eAluImm   (eAluImm),
        .eDest     (eDest),
        .eOpA      (eOpA),
        .eOpB      (eOpB),
        .eImm      (eImm),
        .exeResult (exeResult),
        .mWreg     (mWreg),
        .mIsLoad   (mIsLoad),
        .mDest     (mDest),
        .mResult   (mResult)
    );

    memWbStage uMemWb
    (
        .clk        (clk),
        .rst        (rst),
        .mWreg      (mWreg),
        .mIsLoad    (mIsLoad),
        .mDest      (mDest),
        .mResult    (mResult),
        .memFwdData (memFwdData),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

endmodule

/* testbench/cpuPipeTb.sv */
`timescale 1ns/1ps
`include "cpuPipeCfg.svh"

module cpuPipeTb;
    import isaPkg::*;

    logic      clk;
    logic      rst;
    logic      run;
    logic      imemWe;
    imemAddr_t imemAddr;
    word_t     imemData;
    logic      wbValid;
    regIdx_t   wbReg;
    word_t     wbData;

    integer  seed = 86;
    word_t   prog [$];
    regIdx_t expReg [$];
    word_t   expData [$];
    int      checkedCount;

    cpuPipeTop u_dut
    (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // error handling and compares
    //////////////////////////////

    task automatic stopOnError();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkReg(input string name, input regIdx_t expected, input regIdx_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected %h got %h", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected %h got %h", name, expected, actual);
            stopOnError();
        end
    endtask

    //////////////////////////////
    // instruction encoding
    //////////////////////////////

    function automatic word_t encodeRType(funct_e fn, regIdx_t rd, regIdx_t rs, regIdx_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'b00000, fn};
    endfunction

    // rt <- mem[rs + off]
    function automatic word_t encodeLoad(regIdx_t rt, regIdx_t rs, logic [15:0] off);
        return {OP_LW, rs, rt, off};
    endfunction

    function automatic regIdx_t pickReg();
        logic [31:0] v;
        v = $random(seed);
        return regIdx_t'(v[3:0] % 4'd15 + 4'd1);
    endfunction

    // next register in 1..15
    function automatic regIdx_t nextReg(input regIdx_t r);
        return (r == 5'd15) ? 5'd1 : r + 5'd1;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    // in-order execution from the reset contents, one entry per register write
    function automatic void computeExpected();
        word_t   regs [32];
        word_t   mem [32];
        word_t   instr;
        word_t   imm;
        word_t   a;
        word_t   b;
        word_t   addr;
        word_t   val;
        regIdx_t dst;
        logic    hasWb;
        int      i;
        int      k;
        for (i = 0; i < 32; i++)
        begin
            regs[i] = word_t'(i) * `CPU_REG_INIT_STEP;
            mem[i]  = `CPU_DMEM_INIT_BASE + word_t'(i) * `CPU_DMEM_INIT_STEP;
        end
        for (k = 0; k < prog.size(); k++)
        begin
            instr = prog[k];
            imm   = {{16{instr[15]}}, instr[15:0]};
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            hasWb = 1'b0;
            val   = '0;
            dst   = '0;
            if (instr[31:26] == OP_LW)
            begin
                addr  = a + imm;
                val   = mem[addr[6:2]];
                dst   = instr[20:16];
                hasWb = 1'b1;
            end
            else if (instr[31:26] == OP_RTYPE)
            begin
                dst   = instr[15:11];
                hasWb = 1'b1;
                case (instr[5:0])
                    FN_ADD:  val = a + b;
                    FN_SUB:  val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    default: hasWb = 1'b0;
                endcase
            end
            // r0 never changes and never shows a writeback
            if (hasWb && (dst != '0))
            begin
                regs[dst] = val;
                expReg.push_back(dst);
                expData.push_back(val);
            end
        end
    endfunction

    //////////////////////////////
    // writeback monitor
    //////////////////////////////

    always @(negedge clk)
    begin
        if (!rst && (wbValid === 1'b1))
        begin
            if (expReg.size() == 0)
            begin
                $display("writeback to register %h arrived when none was expected", wbReg);
                stopOnError();
            end
            else
            begin
                checkReg("wbReg", expReg.pop_front(), wbReg);
                checkWord("wbData", expData.pop_front(), wbData);
                checkedCount++;
            end
        end
    end

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic applyReset();
        @(posedge clk);
        rst    <= 1'b1;
        run    <= 1'b0;
        imemWe <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // program from the reset pc on, nops in every other word
    task automatic loadImem();
        int i;
        for (i = 0; i < `CPU_IMEM_WORDS; i++)
        begin
            @(posedge clk);
            imemWe   <= 1'b1;
            imemAddr <= imemAddr_t'((`CPU_RESET_PC >> 2) + i);
            imemData <= (i < prog.size()) ? prog[i] : '0;
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic expectQuiet(input int cycles);
        int i;
        for (i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (wbValid !== 1'b0)
            begin
                $display("a writeback appeared while run was low");
                stopOnError();
            end
        end
    endtask

    task automatic waitDrain(input string label);
        int waited;
        waited = 0;
        while (expReg.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > 50)
            begin
                $display("timed out in %s with %0d writebacks still missing", label,
                         expReg.size());
                stopOnError();
            end
        end
        // room for any stray pulse to show up
        repeat (6) @(posedge clk);
    endtask

    task automatic runProgram(input string label);
        applyReset();
        loadImem();
        computeExpected();
        expectQuiet(10);
        @(posedge clk);
        run <= 1'b1;
        // a few nops behind the program, well short of wrapping back
        repeat (prog.size() + 4) @(posedge clk);
        run <= 1'b0;
        waitDrain(label);
        $display("%s finished, %0d writebacks compared so far", label, checkedCount);
    endtask

    task automatic buildRandomProgram(input int count);
        int          k;
        logic [31:0] v;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     rd;
        regIdx_t     loadDest;
        logic        prevLoad;
        logic [15:0] off;
        funct_e      fn;
        prog.delete();
        prevLoad = 1'b0;
        loadDest = '0;
        for (k = 0; k < count; k++)
        begin
            v  = $random(seed);
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            // keep a load result away from the very next instruction
            if (prevLoad && (rs == loadDest))
                rs = nextReg(rs);
            if (prevLoad && (rt == loadDest))
                rt = nextReg(rt);
            if (v[1:0] == 2'b00)
            begin
                off = {{9{v[12]}}, v[12:6]};
                prog.push_back(encodeLoad(rt, rs, off));
                prevLoad = 1'b1;
                loadDest = rt;
            end
            else
            begin
                case (v[4:2] % 3'd5)
                    3'd0:    fn = FN_ADD;
                    3'd1:    fn = FN_SUB;
                    3'd2:    fn = FN_AND;
                    3'd3:    fn = FN_OR;
                    default: fn = FN_XOR;
                endcase
                prog.push_back(encodeRType(fn, rd, rs, rt));
                prevLoad = 1'b0;
            end
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        run          = 1'b0;
        imemWe       = 1'b0;
        imemAddr     = '0;
        imemData     = '0;
        checkedCount = 0;

        // independent ops, sources untouched by earlier writes
        prog.delete();
        prog.push_back(encodeRType(FN_ADD, 5'd16, 5'd1, 5'd2));
        prog.push_back(encodeRType(FN_SUB, 5'd17, 5'd3, 5'd4));
        prog.push_back(encodeRType(FN_AND, 5'd18, 5'd5, 5'd6));
        prog.push_back(encodeRType(FN_OR, 5'd19, 5'd7, 5'd8));
        prog.push_back(encodeRType(FN_XOR, 5'd20, 5'd9, 5'd10));
        runProgram("independent ops");

        // back-to-back chain through execute, memory and regfile bypass
        prog.delete();
        prog.push_back(encodeRType(FN_ADD, 5'd1, 5'd2, 5'd3));
        prog.push_back(encodeRType(FN_SUB, 5'd4, 5'd1, 5'd2));
        prog.push_back(encodeRType(FN_XOR, 5'd5, 5'd4, 5'd1));
        prog.push_back(encodeRType(FN_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(encodeRType(FN_AND, 5'd7, 5'd6, 5'd4));
        prog.push_back(encodeRType(FN_ADD, 5'd8, 5'd7, 5'd7));
        runProgram("dependent chain");

        // loads, negative offsets, consumers two behind
        prog.delete();
        prog.push_back(encodeLoad(5'd1, 5'd2, 16'd8));
        prog.push_back(encodeLoad(5'd3, 5'd5, 16'(-12)));
        prog.push_back(encodeRType(FN_ADD, 5'd9, 5'd1, 5'd4));
        prog.push_back(encodeLoad(5'd6, 5'd3, 16'(-100)));
        prog.push_back(encodeRType(FN_SUB, 5'd11, 5'd9, 5'd2));
        prog.push_back(encodeRType(FN_XOR, 5'd10, 5'd6, 5'd3));
        runProgram("loads");

        // r0 as destination is silent and still reads as zero
        prog.delete();
        prog.push_back(encodeRType(FN_ADD, 5'd0, 5'd1, 5'd2));
        prog.push_back(encodeRType(FN_OR, 5'd0, 5'd3, 5'd3));
        prog.push_back(encodeLoad(5'd0, 5'd1, 16'd4));
        prog.push_back(encodeRType(FN_ADD, 5'd5, 5'd0, 5'd0));
        prog.push_back(encodeRType(FN_SUB, 5'd6, 5'd7, 5'd0));
        prog.push_back(encodeRType(FN_XOR, 5'd8, 5'd0, 5'd9));
        runProgram("register zero");

        buildRandomProgram(20);
        runProgram("random program");

        $display(">>> PASS");
        $finish;
    end

endmodule

/* cpuPipeTop.f */
+incdir+hw
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/cpuPipeTop.sv
testbench/cpuPipeTb.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f cpuPipeTop.f --top-module cpuPipeTb; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcpuPipeTb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF ">>> PASS" <<< "$output"; then
    exit 0
fi
exit 1
